// File: design/mmio_pkg.sv
package mmio_pkg;

    // cpu transfer kind, encoding kept from the cpu side
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        WRITE = 2'b01,
        READ  = 2'b10,
        FETCH = 2'b11
    } rwi_e;

    // decoded target of an access
    typedef enum logic [2:0] {
        FETCH_MEM,
        EXT_REG,
        DATA_MEM,
        TFT,
        NONE
    } region_e;

    // inclusive upper bounds of the address map
    localparam logic [31:0] FETCH_TOP = 32'd1024;
    localparam logic [31:0] REG_TOP   = 32'd1056;
    localparam logic [31:0] DATA_TOP  = 32'd1792;
    localparam logic [31:0] TFT_TOP   = 32'd2047;

    localparam logic [7:0]  BUS_BASE  = 8'h33;         // upper byte seen on the bus
    localparam logic [31:0] NO_INSTR  = 32'hDEADBEEF;  // instr when no fetch is served

    // decoder -> wishbone manager, 66 bits
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // decoder -> display writer, 41 bits
    typedef struct packed {
        logic        wr;
        logic [7:0]  addr;
        logic [31:0] data;
    } tft_req_t;

    typedef enum logic [1:0] {WB_IDLE, WB_BUS, WB_DONE} wb_state_e;

    typedef enum logic {TFT_IDLE, TFT_SHIFT} tft_state_e;

endpackage

// File: design/mmio_decoder.sv
`timescale 1ns/100ps

module mmio_decoder (
    input  mmio_pkg::rwi_e     rwi,       // idle, write, read or fetch
    input  logic [31:0]        addr,
    input  logic [31:0]        wdata,
    input  logic [31:0]        rdata,     // word held by the wb manager
    input  logic               bus_busy,
    input  logic [31:0]        reg_data,
    input  logic               chip_sel,  // low while the register file loads
    input  logic               tft_busy,
    output mmio_pkg::bus_req_t bus_req,
    output logic [4:0]         reg_addr,
    output mmio_pkg::tft_req_t tft_req,
    output logic [31:0]        read_data,
    output logic [31:0]        instr,
    output logic               busy
);

    mmio_pkg::region_e region;
    logic              bus_rd;     // read or fetch
    logic              reg_wait;   // register read blocked by a load

    // address map, bounds are inclusive
    always_comb begin
        if (addr <= mmio_pkg::FETCH_TOP) begin
            region = mmio_pkg::FETCH_MEM;
        end else if (addr <= mmio_pkg::REG_TOP) begin
            region = mmio_pkg::EXT_REG;
        end else if (addr <= mmio_pkg::DATA_TOP) begin
            region = mmio_pkg::DATA_MEM;
        end else if (addr <= mmio_pkg::TFT_TOP) begin
            region = mmio_pkg::TFT;
        end else begin
            region = mmio_pkg::NONE;
        end
    end

    assign bus_rd = (rwi == mmio_pkg::READ) || (rwi == mmio_pkg::FETCH);

    always_comb begin
        // addresses and payload always follow the cpu, strobes decide
        bus_req       = '0;
        bus_req.addr  = {mmio_pkg::BUS_BASE, addr[23:0]};
        bus_req.wdata = wdata;
        tft_req.wr    = 1'b0;
        tft_req.addr  = addr[7:0];   // display sees the low byte only
        tft_req.data  = wdata;
        reg_addr      = 5'(addr - (mmio_pkg::FETCH_TOP + 32'd1));   // entry 0 just above code
        read_data     = '0;
        instr         = mmio_pkg::NO_INSTR;

        case (region)
            mmio_pkg::FETCH_MEM, mmio_pkg::DATA_MEM: begin
                // hold off the bus while a display frame is going out,
                // otherwise the held request would restart the manager
                if (!tft_busy) begin
                    bus_req.read  = bus_rd;
                    bus_req.write = (rwi == mmio_pkg::WRITE) &&
                                    (region == mmio_pkg::DATA_MEM);   // no writes to code
                end
                if (rwi == mmio_pkg::READ) begin
                    read_data = rdata;
                end
                if (rwi == mmio_pkg::FETCH) begin
                    instr = rdata;   // valid in the manager's DONE cycle
                end
            end
            mmio_pkg::EXT_REG: begin
                if (rwi == mmio_pkg::READ && chip_sel) begin
                    read_data = reg_data;   // combinational, no wait
                end
            end
            mmio_pkg::TFT: begin
                tft_req.wr = (rwi == mmio_pkg::WRITE);   // posted
            end
            default: begin
                // unmapped, nothing is driven
            end
        endcase
    end

    assign reg_wait = (rwi == mmio_pkg::READ) && (region == mmio_pkg::EXT_REG) && !chip_sel;

    // single stall level back to the cpu
    assign busy = tft_busy || bus_busy || reg_wait;

endmodule

// File: design/wb_manager.sv
`timescale 1ns/100ps

module wb_manager (
    input  logic               clk,
    input  logic               reset,
    input  mmio_pkg::bus_req_t req,
    output logic               cyc,
    output logic               stb,
    output logic               we,
    output logic [31:0]        adr,
    output logic [31:0]        dat_w,
    input  logic [31:0]        dat_r,
    input  logic               ack,
    output logic [31:0]        rdata,
    output logic               bus_busy
);

    mmio_pkg::wb_state_e state;
    mmio_pkg::wb_state_e state_nxt;
    logic                req_valid;
    logic                active;    // cycle on the bus this clock

    assign req_valid = req.read || req.write;

    // the cycle opens in IDLE already, so the memory sees stb with the request
    assign active = (state == mmio_pkg::WB_BUS) ||
                    ((state == mmio_pkg::WB_IDLE) && req_valid);

    assign cyc      = active;
    assign stb      = active;   // stays up until ack
    assign we       = req.write;
    assign adr      = req.addr;    // cpu holds the request steady while busy
    assign dat_w    = req.wdata;
    assign bus_busy = active;      // low in DONE, that is the completing cycle

    always_comb begin
        state_nxt = state;
        case (state)
            mmio_pkg::WB_IDLE: begin
                if (req_valid) begin
                    state_nxt = mmio_pkg::WB_BUS;
                end
            end
            mmio_pkg::WB_BUS: begin
                if (ack) begin
                    state_nxt = mmio_pkg::WB_DONE;
                end
            end
            mmio_pkg::WB_DONE: state_nxt = mmio_pkg::WB_IDLE;   // cpu moves on here
            default:           state_nxt = mmio_pkg::WB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mmio_pkg::WB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // returned word, held through DONE and beyond
    always_ff @(posedge clk) begin
        if (active && ack) begin
            rdata <= dat_r;
        end
    end

endmodule

// File: design/wb_memory.sv
`timescale 1ns/100ps

module wb_memory #(
    parameter int WAIT_STATES = 2,
    parameter int MEM_WORDS   = 2048
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(WAIT_STATES + 2);
    localparam logic [CNT_W-1:0] LAST_WAIT = CNT_W'(WAIT_STATES);

    logic [31:0]      mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] wait_cnt;
    logic             fire;       // last wait cycle, access happens at this edge

    initial $readmemh("program.hex", mem);   // code image at word 0 up

    assign idx  = adr[IDX_W-1:0];   // word index, upper byte is the bus base
    assign fire = cyc && stb && !ack && (wait_cnt == LAST_WAIT) && !reset;

    // ack comes WAIT_STATES+1 clocks after stb is first seen
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
            ack      <= 1'b0;
        end else if (ack) begin
            ack      <= 1'b0;     // single cycle pulse
            wait_cnt <= '0;
        end else if (fire) begin
            ack      <= 1'b1;
            wait_cnt <= '0;
        end else if (cyc && stb) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // access lands together with ack
    always_ff @(posedge clk) begin
        if (fire) begin
            if (we) begin
                mem[idx] <= dat_w;
            end else begin
                dat_r <= mem[idx];
            end
        end
    end

endmodule

// File: design/ext_registers.sv
`timescale 1ns/100ps

module ext_registers (
    input  logic        clk,
    input  logic        reset,
    input  logic        load,        // strobe from the outside agent
    input  logic [4:0]  load_idx,
    input  logic [31:0] load_data,
    input  logic [4:0]  reg_addr,
    output logic [31:0] reg_data,
    output logic        chip_sel     // high when reads are safe
);

    logic [31:0] regs [32];
    logic        load_q;   // load seen last cycle

    always_ff @(posedge clk) begin
        if (load) begin
            regs[load_idx] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load;
        end
    end

    // blocked during the load and one cycle after,
    // so the cpu never samples an entry mid update
    assign chip_sel = !(load || load_q);

    assign reg_data = regs[reg_addr];   // plain combinational read

endmodule

// File: design/tft_writer.sv
`timescale 1ns/100ps

module tft_writer (
    input  logic               clk,
    input  logic               reset,
    input  mmio_pkg::tft_req_t req,
    output logic               tft_busy,
    output logic               sclk,
    output logic               mosi,
    output logic               cs_n
);

    localparam int FRAME_BITS = 40;   // 8 address + 32 data
    localparam logic [5:0] LAST_BIT = 6'(FRAME_BITS - 1);

    mmio_pkg::tft_state_e  state;
    logic [FRAME_BITS-1:0] frame;     // msb goes out first
    logic [5:0]            bit_cnt;
    logic                  accept;

    assign accept = (state == mmio_pkg::TFT_IDLE) && req.wr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= mmio_pkg::TFT_IDLE;
            sclk    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            case (state)
                mmio_pkg::TFT_IDLE: begin
                    if (accept) begin
                        state   <= mmio_pkg::TFT_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                mmio_pkg::TFT_SHIFT: begin
                    sclk <= ~sclk;   // two clocks per bit
                    if (sclk) begin
                        if (bit_cnt == LAST_BIT) begin
                            state <= mmio_pkg::TFT_IDLE;   // sclk ends low
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= mmio_pkg::TFT_IDLE;
            endcase
        end
    end

    // load the whole frame at once, shift on the falling sclk edge
    always_ff @(posedge clk) begin
        if (accept) begin
            frame <= {req.addr, req.data};
        end else if (state == mmio_pkg::TFT_SHIFT && sclk) begin
            frame <= {frame[FRAME_BITS-2:0], 1'b0};
        end
    end

    assign tft_busy = (state == mmio_pkg::TFT_SHIFT);   // rises the edge after accept
    assign cs_n     = (state != mmio_pkg::TFT_SHIFT);   // low over the whole frame
    assign mosi     = (state == mmio_pkg::TFT_SHIFT) && frame[FRAME_BITS-1];

endmodule

// File: design/mmio_subsystem.sv
`timescale 1ns/100ps

module mmio_subsystem #(
    parameter int WAIT_STATES = 2,
    parameter int MEM_WORDS   = 2048
) (
    input  logic           clk,
    input  logic           reset,
    input  mmio_pkg::rwi_e rwi,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata,
    output logic [31:0]    read_data,
    output logic [31:0]    instr,
    output logic           busy,
    input  logic           reg_load,       // register file load port
    input  logic [4:0]     reg_load_idx,
    input  logic [31:0]    reg_load_data,
    output logic           sclk,           // display link
    output logic           mosi,
    output logic           cs_n
);

    mmio_pkg::bus_req_t bus_req;
    mmio_pkg::tft_req_t tft_req;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic [31:0] rdata;
    logic        bus_busy;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data;
    logic        chip_sel;
    logic        tft_busy;

    mmio_decoder decoder_i (
        .rwi       (rwi),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .bus_busy  (bus_busy),
        .reg_data  (reg_data),
        .chip_sel  (chip_sel),
        .tft_busy  (tft_busy),
        .bus_req   (bus_req),
        .reg_addr  (reg_addr),
        .tft_req   (tft_req),
        .read_data (read_data),
        .instr     (instr),
        .busy      (busy)
    );

    // shared memory path, fetch and data go through the same manager
    wb_manager wb_manager_i (
        .clk      (clk),
        .reset    (reset),
        .req      (bus_req),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .dat_w    (dat_w),
        .dat_r    (dat_r),
        .ack      (ack),
        .rdata    (rdata),
        .bus_busy (bus_busy)
    );

    wb_memory #(
        .WAIT_STATES (WAIT_STATES),
        .MEM_WORDS   (MEM_WORDS)
    ) wb_memory_i (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    ext_registers ext_registers_i (
        .clk       (clk),
        .reset     (reset),
        .load      (reg_load),
        .load_idx  (reg_load_idx),
        .load_data (reg_load_data),
        .reg_addr  (reg_addr),
        .reg_data  (reg_data),
        .chip_sel  (chip_sel)
    );

    tft_writer tft_writer_i (
        .clk      (clk),
        .reset    (reset),
        .req      (tft_req),
        .tft_busy (tft_busy),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs_n     (cs_n)
    );

endmodule

// File: test/mmio_asserts.sv
`timescale 1ns/100ps

module mmio_asserts #(
    parameter int WAIT_STATES = 2
) (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic bus_busy,
    input logic stb,
    input logic ack,
    input logic tft_busy,
    input logic sclk,
    input logic cs_n
);

    // first cycle out of reset, the cpu side is quiet
    busy_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy)
        else $error("busy high right after reset");

    // a strobe never drops before the memory answers
    stb_until_ack: assert property (@(posedge clk) disable iff (reset)
        (stb && !ack) |=> stb)
        else $error("stb dropped before ack");

    // 40 bits at two clocks each, last cycle has sclk high,
    // then the writer idles with cs_n high and sclk low
    cs_frame: assert property (@(posedge clk) disable iff (reset)
        $rose(tft_busy) |-> ##79 (!cs_n && sclk) ##1 (cs_n && !sclk))
        else $error("display frame did not end after 80 cycles with cs_n high");

    // request seen in cycle 0, ack in cycle WAIT_STATES+1, busy low one later
    bus_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(bus_busy) |-> ##(WAIT_STATES + 1) (bus_busy && ack) ##1 !busy)
        else $error("bus access did not finish in WAIT_STATES+2 cycles");

endmodule

// File: test/mmio_tb.sv
`timescale 1ns/100ps

module mmio_tb;

    localparam int WAIT_STATES = 2;
    localparam int MEM_WORDS   = 2048;
    localparam int ACCESS_MAX  = WAIT_STATES + 4;    // request, waits, done, idle
    localparam int TFT_MAX     = 2 * 40 + 8;
    localparam int NUM_ACCESS  = 48;
    localparam int WATCHDOG_CYCLES = 2 * (10 + NUM_ACCESS * ACCESS_MAX + 2 * TFT_MAX + 40);

    logic           clk;
    logic           reset;
    mmio_pkg::rwi_e rwi;
    logic [31:0]    addr;
    logic [31:0]    wdata;
    logic [31:0]    read_data;
    logic [31:0]    instr;
    logic           busy;
    logic           reg_load;
    logic [4:0]     reg_load_idx;
    logic [31:0]    reg_load_data;
    logic           sclk;
    logic           mosi;
    logic           cs_n;

    logic [31:0] rom_model [16];          // image of program.hex
    logic [31:0] data_shadow [int];       // data region, keyed by cpu address
    logic [31:0] reg_shadow [32];
    logic [15:0] lfsr_state = 16'd71;
    logic [39:0] spi_word;                // deserialized frame
    int          spi_bits;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mmio_subsystem #(
        .WAIT_STATES (WAIT_STATES),
        .MEM_WORDS   (MEM_WORDS)
    ) mmio_subsystem_i (
        .clk           (clk),
        .reset         (reset),
        .rwi           (rwi),
        .addr          (addr),
        .wdata         (wdata),
        .read_data     (read_data),
        .instr         (instr),
        .busy          (busy),
        .reg_load      (reg_load),
        .reg_load_idx  (reg_load_idx),
        .reg_load_data (reg_load_data),
        .sclk          (sclk),
        .mosi          (mosi),
        .cs_n          (cs_n)
    );

    bind mmio_subsystem mmio_asserts #(.WAIT_STATES(WAIT_STATES)) asserts_i (
        .clk      (clk),
        .reset    (reset),
        .busy     (busy),
        .bus_busy (bus_busy),
        .stb      (stb),
        .ack      (ack),
        .tft_busy (tft_busy),
        .sclk     (sclk),
        .cs_n     (cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns
    end

    // 16 bit fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);   // one step per bit
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // mosi is stable at the rising sclk edge
    initial begin
        spi_word = '0;
        spi_bits = 0;
        forever begin
            @(posedge sclk);
            if (!cs_n) begin
                spi_word = {spi_word[38:0], mosi};
                spi_bits++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a test hung", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // one cpu access, held while busy, dropped the edge after completion
    task automatic cpu_access(input mmio_pkg::rwi_e kind, input logic [31:0] a,
                              input logic [31:0] d, output logic [31:0] rd,
                              output logic [31:0] ins, output int waits);
        waits = 0;
        @(posedge clk);
        rwi      <= kind;
        addr     <= a;
        wdata    <= d;
        reg_load <= 1'b0;   // a pending load strobe ends here
        @(negedge clk);
        while (busy) begin
            waits++;
            @(negedge clk);
        end
        rd  = read_data;
        ins = instr;
        @(posedge clk);
        rwi <= mmio_pkg::IDLE;
    endtask

    task automatic start_load(input logic [4:0] idx, input logic [31:0] d);
        @(posedge clk);
        reg_load      <= 1'b1;
        reg_load_idx  <= idx;
        reg_load_data <= d;
        reg_shadow[idx] = d;
    endtask

    task automatic load_register(input logic [4:0] idx, input logic [31:0] d);
        start_load(idx, d);
        @(posedge clk);
        reg_load <= 1'b0;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_before);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] ins;
        logic [31:0] d;
        logic [31:0] a;
        int          waits;
        int          err0;

        reset         = 1'b1;
        rwi           = mmio_pkg::IDLE;
        addr          = '0;
        wdata         = '0;
        reg_load      = 1'b0;
        reg_load_idx  = '0;
        reg_load_data = '0;
        $readmemh("test/program.hex", rom_model);
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // fetches from code, and a data read gives no instruction
        err0 = errors;
        for (int i = 0; i < 16; i++) begin
            cpu_access(mmio_pkg::FETCH, i, '0, rd, ins, waits);
            check_value($sformatf("fetch %0d instr", i), ins, rom_model[i]);
        end
        cpu_access(mmio_pkg::READ, 32'd1200, '0, rd, ins, waits);
        check_value("instr on data read", ins, mmio_pkg::NO_INSTR);
        finish_test("fetch", err0);

        // data region write then read back
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = 32'd1100 + i * 7;
            d = random_word();
            data_shadow[a] = d;
            cpu_access(mmio_pkg::WRITE, a, d, rd, ins, waits);
        end
        for (int i = 0; i < 4; i++) begin
            a = 32'd1100 + i * 7;
            cpu_access(mmio_pkg::READ, a, '0, rd, ins, waits);
            check_value($sformatf("data read %0d", a), rd, data_shadow[a]);
        end
        finish_test("data memory", err0);

        // register file, plain reads and a read right after a load
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            load_register(5'(i), random_word());
        end
        for (int i = 0; i < 8; i++) begin
            cpu_access(mmio_pkg::READ, 32'd1025 + i, '0, rd, ins, waits);
            check_value($sformatf("register %0d", i), rd, reg_shadow[i]);
        end
        start_load(5'd2, random_word());
        cpu_access(mmio_pkg::READ, 32'd1027, '0, rd, ins, waits);
        assert (waits > 0) else begin
            $display("register read right after a load was not held busy");
            errors++;
        end
        check_value("register 2 after load", rd, reg_shadow[2]);
        finish_test("registers", err0);

        // posted display write, next access held over the frame
        err0 = errors;
        d = random_word();
        spi_bits = 0;
        cpu_access(mmio_pkg::WRITE, 32'd1800, d, rd, ins, waits);
        cpu_access(mmio_pkg::READ, 32'd1028, '0, rd, ins, waits);
        assert (waits >= 78) else begin
            $display("access during a display frame finished after only %0d waits", waits);
            errors++;
        end
        check_value("register 3 after frame", rd, reg_shadow[3]);
        assert (spi_bits == 40) else begin
            $display("display frame had %0d bits instead of 40", spi_bits);
            errors++;
        end
        check_value("frame address byte", {24'h0, spi_word[39:32]}, 32'h08);
        check_value("frame data", spi_word[31:0], d);
        finish_test("display link", err0);

        // ignored accesses leave all contents alone
        err0 = errors;
        cpu_access(mmio_pkg::READ, 32'd2100, '0, rd, ins, waits);
        check_value("unmapped read", rd, '0);
        cpu_access(mmio_pkg::WRITE, 32'd1030, random_word(), rd, ins, waits);
        cpu_access(mmio_pkg::WRITE, 32'd3148, random_word(), rd, ins, waits);  // low bits hit word 1100
        cpu_access(mmio_pkg::READ, 32'd1030, '0, rd, ins, waits);
        check_value("register 5 after region write", rd, reg_shadow[5]);
        for (int i = 0; i < 4; i++) begin
            a = 32'd1100 + i * 7;
            cpu_access(mmio_pkg::READ, a, '0, rd, ins, waits);
            check_value($sformatf("data %0d reread", a), rd, data_shadow[a]);
        end
        cpu_access(mmio_pkg::FETCH, 32'd0, '0, rd, ins, waits);
        check_value("fetch 0 reread", ins, rom_model[0]);
        finish_test("ignored accesses", err0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: test/program.hex
// one 32-bit instruction word per line, hex, word address 0 upward
00000013
00100093
00200113
002081b3
40208233
0030f2b3
0040e333
005343b3
00139413
0023d493
00000517
00a00593
00b50633
fff60693
0006a703
00000067

// File: project.f
design/mmio_pkg.sv
design/mmio_decoder.sv
design/wb_manager.sv
design/wb_memory.sv
design/ext_registers.sv
design/tft_writer.sv
design/mmio_subsystem.sv
test/mmio_asserts.sv
test/mmio_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# memory model loads program.hex from the run directory
cp test/program.hex program.hex &&
verilator --binary --timing --assert --top-module mmio_tb -f project.f -o mmio_sim ||
{ echo "build failed"; exit 1; }
./obj_dir/mmio_sim > sim.log 2>&1 || echo "simulator exited with an error"
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
